// File: source/shared_mem_pkg.sv
// shared widths, address map, filler word and control bit positions; import into every RTL module
`default_nettype none

package shared_mem_pkg;

  // word and lane geometry
  localparam int unsigned LANES  = 8;               // byte lanes per word
  localparam int unsigned BYTE_W = 8;               // bits per lane
  localparam int unsigned DATA_W = LANES * BYTE_W;  // full word, 64 bits

  // debug address layout
  localparam int unsigned DBG_ADDR_W = 32;          // debug master address width
  localparam int unsigned ADDR_LSB   = 3;           // byte offset bits below the word index
  localparam int unsigned REGION_LSB = 20;          // region field low bit
  localparam int unsigned REGION_MSB = 23;          // region field high bit
  localparam int unsigned REGION_W   = REGION_MSB - REGION_LSB + 1;

  // region codes seen in debug_addr[23:20]
  localparam logic [REGION_W-1:0] MEM_REGION  = 4'h8;  // scratchpad words
  localparam logic [REGION_W-1:0] CTRL_REGION = 4'hF;  // core control block

  // control block also needs the whole top byte set
  localparam int unsigned CTRL_TAG_W = 8;
  localparam logic [CTRL_TAG_W-1:0] CTRL_TAG = 8'hFF;  // debug_addr[31:24]

  // returned for any debug read that hits nothing
  localparam logic [DATA_W-1:0] FILLER_WORD = 64'h0000_0000_DEAD_BEEF;

  // decoded target of a debug access
  typedef enum logic [1:0] {
    REGION_NONE = 2'd0,  // unmapped, reads give the filler
    REGION_MEM  = 2'd1,  // lane RAMs, port A
    REGION_CTRL = 2'd2   // control register
  } region_e;

  // control word layout, all other bits read as zero
  localparam int unsigned CTRL_HALT_BIT      = 0;  // halt request to the core
  localparam int unsigned CTRL_FETCH_DIS_BIT = 1;  // inverted into fetch_enable_o

endpackage

`default_nettype wire

// File: source/debug_decode.sv
// debug address decoder; steers each debug access to the lane RAMs, the control block or nowhere
`default_nettype none

module debug_decode
  import shared_mem_pkg::*;
#(
  parameter int unsigned WORD_ADDR_W = 11          // word index width, memory depth
) (
  input  logic                   debug_req_i,      // one-cycle access strobe
  input  logic [DBG_ADDR_W-1:0]  debug_addr_i,     // debug byte address
  output logic                   mem_en_o,         // enables port A on all lanes
  output logic                   ctrl_sel_o,       // control block access
  output region_e                region_o,         // tag for the readback mux
  output logic [WORD_ADDR_W-1:0] word_addr_o       // word index into the lanes
);

  logic [REGION_W-1:0]   region_field;             // debug_addr[23:20]
  logic [CTRL_TAG_W-1:0] top_byte;                 // debug_addr[31:24]
  logic                  tag_hit;                  // top byte is all ones

  // word index has to sit below the region field
  if (WORD_ADDR_W + ADDR_LSB > REGION_LSB) begin : g_addr_check
    $error("word address overlaps the region field");
  end

  assign region_field = debug_addr_i[REGION_MSB:REGION_LSB];
  assign top_byte     = debug_addr_i[DBG_ADDR_W-1 -: CTRL_TAG_W];
  assign tag_hit      = (top_byte == CTRL_TAG);

  always_comb begin
    region_o = REGION_NONE;                        // anything else is unmapped
    case (region_field)
      MEM_REGION: begin
        region_o = REGION_MEM;                     // top byte ignored for memory
      end
      CTRL_REGION: begin
        if (tag_hit) begin
          region_o = REGION_CTRL;                  // wrong tag falls back to filler
        end
      end
      default: begin
        region_o = REGION_NONE;
      end
    endcase
  end

  // strobes gated by region, so unmapped writes touch nothing
  assign mem_en_o    = debug_req_i && (region_o == REGION_MEM);
  assign ctrl_sel_o  = debug_req_i && (region_o == REGION_CTRL);

  // byte offset dropped, debug always moves whole words
  assign word_addr_o = debug_addr_i[ADDR_LSB +: WORD_ADDR_W];

endmodule

`default_nettype wire

// File: source/byte_lane_ram.sv
// one byte lane of the shared scratchpad; true dual-port RAM, instantiated once per lane
`default_nettype none

module byte_lane_ram
  import shared_mem_pkg::*;
#(
  parameter int unsigned WORD_ADDR_W = 11          // depth is 2**WORD_ADDR_W
) (
  input  logic                   clk_i,
  // port A, debug side
  input  logic                   a_en_i,           // port enable
  input  logic                   a_we_i,           // write when enabled
  input  logic [WORD_ADDR_W-1:0] a_addr_i,
  input  logic [BYTE_W-1:0]      a_wdata_i,
  output logic [BYTE_W-1:0]      a_rdata_o,        // registered read data
  // port B, system side
  input  logic                   b_en_i,           // strobe and byte enable at the top
  input  logic                   b_we_i,
  input  logic [WORD_ADDR_W-1:0] b_addr_i,
  input  logic [BYTE_W-1:0]      b_wdata_i,
  output logic [BYTE_W-1:0]      b_rdata_o
);

  localparam int unsigned DEPTH = 2 ** WORD_ADDR_W;

  logic [BYTE_W-1:0] mem_q [DEPTH];                // lane storage

  logic a_rd, a_wr;                                // decoded port A action
  logic b_rd, b_wr;                                // decoded port B action

  assign a_rd = a_en_i && !a_we_i;
  assign a_wr = a_en_i && a_we_i;
  assign b_rd = b_en_i && !b_we_i;
  assign b_wr = b_en_i && b_we_i;

  // both ports in one process, nonblocking reads see the array before
  // either write of this edge lands, so a read is always read-before-write
  always_ff @(posedge clk_i) begin
    if (a_rd) begin
      a_rdata_o <= mem_q[a_addr_i];                // holds between reads
    end
    if (b_rd) begin
      b_rdata_o <= mem_q[b_addr_i];                // system data held until next read
    end
    if (a_wr) begin
      mem_q[a_addr_i] <= a_wdata_i;
    end
    if (b_wr) begin
      mem_q[b_addr_i] <= b_wdata_i;
    end
  end

  // debug and system masters must never store to one word together,
  // the winner would be arbitrary in silicon
  property p_no_write_collision;
    @(posedge clk_i) (a_wr && b_wr) |-> (a_addr_i != b_addr_i);
  endproperty

  a_no_write_collision : assert property (p_no_write_collision)
    else $error("debug and system write the same word in one cycle");

endmodule

`default_nettype wire

// File: source/readback_mux.sv
// debug read return path; tags each debug read and picks lane data, control word or filler
`default_nettype none

module readback_mux
  import shared_mem_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              debug_req_i,           // access strobe
  input  logic              debug_we_i,            // low for a read
  input  region_e           region_i,              // from debug_decode, same cycle
  input  logic [DATA_W-1:0] mem_rdata_i,           // lane port A outputs, one cycle late
  input  logic [DATA_W-1:0] ctrl_rdata_i,          // live control word
  output logic [DATA_W-1:0] debug_rdata_o,
  output logic              debug_rvalid_o         // one pulse per read
);

  logic              rd_req;                       // read strobe this cycle
  logic              rvalid_q;
  region_e           region_q;                     // where the pending read went
  logic [DATA_W-1:0] ctrl_q;                       // control word at read time

  assign rd_req = debug_req_i && !debug_we_i;

  // one stage, lines up with the lane RAM output register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      region_q <= REGION_NONE;
    end else begin
      rvalid_q <= rd_req;                          // valid exactly one cycle later
      if (rd_req) begin
        region_q <= region_i;
      end
    end
  end

  // control word sampled like a RAM read
  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      ctrl_q <= ctrl_rdata_i;
    end
  end

  always_comb begin
    case (region_q)
      REGION_MEM:  debug_rdata_o = mem_rdata_i;
      REGION_CTRL: debug_rdata_o = ctrl_q;
      default:     debug_rdata_o = FILLER_WORD;    // unmapped or wrong tag
    endcase
  end

  assign debug_rvalid_o = rvalid_q;

  // writes get no response, only reads produce a valid pulse
  a_rvalid_after_read : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    debug_rvalid_o |-> $past(debug_req_i && !debug_we_i)
  ) else $error("debug read valid without a read strobe");

endmodule

`default_nettype wire

// File: source/core_ctrl.sv
// debug-visible core control register plus the cache-flush request latch
`default_nettype none

module core_ctrl
  import shared_mem_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  // control register access from the debug side
  input  logic              ctrl_sel_i,            // decoded control block strobe
  input  logic              debug_we_i,
  input  logic [DATA_W-1:0] debug_wdata_i,
  output logic [DATA_W-1:0] ctrl_rdata_o,          // sampled by readback_mux
  // flush handshake
  input  logic              flush_req_i,           // pulse, sets the latch
  input  logic              flush_ack_i,           // pulse, clears the latch
  output logic              flushing_o,            // level while a flush is pending
  // levels to the core
  output logic              debug_halt_req_o,
  output logic              fetch_enable_o
);

  logic halt_q;                                    // CTRL_HALT_BIT
  logic fetch_dis_q;                               // CTRL_FETCH_DIS_BIT
  logic flush_q;
  logic ctrl_wr;

  assign ctrl_wr = ctrl_sel_i && debug_we_i;

  // control bits, core runs freely out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      halt_q      <= 1'b0;
      fetch_dis_q <= 1'b0;                         // fetch enabled after reset
    end else if (ctrl_wr) begin
      halt_q      <= debug_wdata_i[CTRL_HALT_BIT];
      fetch_dis_q <= debug_wdata_i[CTRL_FETCH_DIS_BIT];
    end
  end

  // readback, unused bits zero
  always_comb begin
    ctrl_rdata_o                     = '0;
    ctrl_rdata_o[CTRL_HALT_BIT]      = halt_q;
    ctrl_rdata_o[CTRL_FETCH_DIS_BIT] = fetch_dis_q;
  end

  assign debug_halt_req_o = halt_q;
  assign fetch_enable_o   = !fetch_dis_q;          // stored inverted so reset gives 1

  // request set / acknowledge clear, request checked last so it wins a tie
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_q <= 1'b0;
    end else begin
      if (flush_ack_i) begin
        flush_q <= 1'b0;                           // cache finished flushing
      end
      if (flush_req_i) begin
        flush_q <= 1'b1;
      end
    end
  end

  assign flushing_o = flush_q;

  // the pending flush may only drop after the cache acknowledged it
  a_flush_held_until_ack : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $fell(flushing_o) |-> $past(flush_ack_i && !flush_req_i)
  ) else $error("flush request dropped without acknowledge");

endmodule

`default_nettype wire

// File: source/shared_mem_top.sv
// shared scratchpad top; debug and system masters on one word-wide RAM, plus core control block
`default_nettype none

module shared_mem_top
  import shared_mem_pkg::*;
#(
  parameter int unsigned WORD_ADDR_W = 11          // 2048 words by default
) (
  input  logic                            clk_i,   // both ports
  input  logic                            rst_ni,
  // debug master
  input  logic                            debug_req_i,
  input  logic                            debug_we_i,
  input  logic [DBG_ADDR_W-1:0]           debug_addr_i,
  input  logic [DATA_W-1:0]               debug_wdata_i,
  output logic [DATA_W-1:0]               debug_rdata_o,
  output logic                            debug_rvalid_o,
  // system master, byte addressed
  input  logic                            sys_req_i,
  input  logic                            sys_we_i,
  input  logic [WORD_ADDR_W+ADDR_LSB-1:0] sys_addr_i,
  input  logic [LANES-1:0]                sys_be_i,
  input  logic [DATA_W-1:0]               sys_wdata_i,
  output logic [DATA_W-1:0]               sys_rdata_o,
  // core side
  input  logic                            flush_req_i,
  input  logic                            flush_ack_i,
  output logic                            flushing_o,
  output logic                            debug_halt_req_o,
  output logic                            fetch_enable_o
);

  logic                   dbg_mem_en;              // port A enable, all lanes
  logic                   dbg_ctrl_sel;
  region_e                dbg_region;
  logic [WORD_ADDR_W-1:0] dbg_word_addr;
  logic [WORD_ADDR_W-1:0] sys_word_addr;
  logic [LANES-1:0]       sys_lane_en;             // port B enable per lane
  logic [DATA_W-1:0]      mem_rdata;               // port A read word
  logic [DATA_W-1:0]      ctrl_rdata;

  debug_decode #(.WORD_ADDR_W(WORD_ADDR_W)) u_decode (
    .debug_req_i  (debug_req_i),
    .debug_addr_i (debug_addr_i),
    .mem_en_o     (dbg_mem_en),
    .ctrl_sel_o   (dbg_ctrl_sel),
    .region_o     (dbg_region),
    .word_addr_o  (dbg_word_addr)
  );

  assign sys_word_addr = sys_addr_i[ADDR_LSB +: WORD_ADDR_W];

  for (genvar lane = 0; lane < LANES; lane++) begin : g_lane
    // reads open every lane, writes only the enabled bytes
    assign sys_lane_en[lane] = sys_req_i && (!sys_we_i || sys_be_i[lane]);

    byte_lane_ram #(.WORD_ADDR_W(WORD_ADDR_W)) u_ram (
      .clk_i     (clk_i),
      .a_en_i    (dbg_mem_en),
      .a_we_i    (debug_we_i),
      .a_addr_i  (dbg_word_addr),
      .a_wdata_i (debug_wdata_i[lane*BYTE_W +: BYTE_W]),
      .a_rdata_o (mem_rdata[lane*BYTE_W +: BYTE_W]),
      .b_en_i    (sys_lane_en[lane]),
      .b_we_i    (sys_we_i),
      .b_addr_i  (sys_word_addr),
      .b_wdata_i (sys_wdata_i[lane*BYTE_W +: BYTE_W]),
      .b_rdata_o (sys_rdata_o[lane*BYTE_W +: BYTE_W])
    );
  end

  readback_mux u_readback (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .debug_req_i    (debug_req_i),
    .debug_we_i     (debug_we_i),
    .region_i       (dbg_region),
    .mem_rdata_i    (mem_rdata),
    .ctrl_rdata_i   (ctrl_rdata),
    .debug_rdata_o  (debug_rdata_o),
    .debug_rvalid_o (debug_rvalid_o)
  );

  core_ctrl u_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .ctrl_sel_i       (dbg_ctrl_sel),
    .debug_we_i       (debug_we_i),
    .debug_wdata_i    (debug_wdata_i),
    .ctrl_rdata_o     (ctrl_rdata),
    .flush_req_i      (flush_req_i),
    .flush_ack_i      (flush_ack_i),
    .flushing_o       (flushing_o),
    .debug_halt_req_o (debug_halt_req_o),
    .fetch_enable_o   (fetch_enable_o)
  );

endmodule

`default_nettype wire

// File: testbench/tb_shared_mem.sv
// testbench for shared_mem_top; drives both masters, flush and control, assertions compare to a model
`default_nettype none

module tb_shared_mem
  import shared_mem_pkg::*;
();

  localparam int unsigned WORD_ADDR_W    = 11;
  localparam int unsigned SYS_ADDR_W     = WORD_ADDR_W + ADDR_LSB;
  localparam int          POOL           = 16;      // words the test works on
  localparam int          MIXED_CYCLES   = 1000;
  localparam int          TIMEOUT_CYCLES = 3000;    // roughly twice the stimulus length
  localparam logic [1:0]  RG_NONE        = 2'd0;
  localparam logic [1:0]  RG_MEM         = 2'd1;
  localparam logic [1:0]  RG_CTRL        = 2'd2;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   debug_req_i;
  logic                   debug_we_i;
  logic [DBG_ADDR_W-1:0]  debug_addr_i;
  logic [DATA_W-1:0]      debug_wdata_i;
  logic [DATA_W-1:0]      debug_rdata_o;
  logic                   debug_rvalid_o;
  logic                   sys_req_i;
  logic                   sys_we_i;
  logic [SYS_ADDR_W-1:0]  sys_addr_i;
  logic [LANES-1:0]       sys_be_i;
  logic [DATA_W-1:0]      sys_wdata_i;
  logic [DATA_W-1:0]      sys_rdata_o;
  logic                   flush_req_i;
  logic                   flush_ack_i;
  logic                   flushing_o;
  logic                   debug_halt_req_o;
  logic                   fetch_enable_o;

  logic [DATA_W-1:0]      ref_mem [2**WORD_ADDR_W];  // expected scratchpad contents
  logic [DATA_W-1:0]      exp_dbg_q;                 // expected debug read word
  logic [DATA_W-1:0]      exp_sys_q;                 // expected system read word
  logic                   sys_seen_q;                // a system read has happened
  logic                   model_halt;
  logic                   model_fetch_dis;
  logic                   model_flush;
  logic [31:0]            rng_state = 32'hb2e3_cab8;
  logic [WORD_ADDR_W-1:0] pool [POOL];
  int                     cycle_cnt = 0;
  int                     err_data = 0;
  int                     err_timing = 0;
  int                     err_ctrl = 0;

  shared_mem_top #(.WORD_ADDR_W(WORD_ADDR_W)) UUT (.*);  // all port names match

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // expected target of a debug address, straight from the address map
  function automatic logic [1:0] region_of(input logic [DBG_ADDR_W-1:0] a);
    if (a[REGION_MSB:REGION_LSB] == MEM_REGION) return RG_MEM;
    if (a[REGION_MSB:REGION_LSB] == CTRL_REGION && a[31:24] == CTRL_TAG) return RG_CTRL;
    return RG_NONE;
  endfunction

  function automatic logic [DBG_ADDR_W-1:0] region_addr(input logic [WORD_ADDR_W-1:0] w,
                                                        input logic [3:0] region,
                                                        input logic [7:0] top);
    logic [DBG_ADDR_W-1:0] a;
    a = '0;
    a[31:24] = top;                                   // ignored outside the control block
    a[REGION_MSB:REGION_LSB] = region;
    a[ADDR_LSB +: WORD_ADDR_W] = w;
    return a;
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                    input logic [DATA_W-1:0] new_w,
                                                    input logic [LANES-1:0] be);
    logic [DATA_W-1:0] m;
    m = old_w;
    for (int l = 0; l < LANES; l++) begin
      if (be[l]) m[l*BYTE_W +: BYTE_W] = new_w[l*BYTE_W +: BYTE_W];
    end
    return m;
  endfunction

  task automatic next_random(output logic [31:0] v);
    rng_state = xorshift32(rng_state);
    v = rng_state;
  endtask

  task automatic random_word(output logic [DATA_W-1:0] v);
    logic [31:0] hi;
    logic [31:0] lo;
    next_random(hi);
    next_random(lo);
    v = {hi, lo};
  endtask

  // one clock of traffic on both ports, flush lines idle
  task automatic drive_cycle(input logic d_req, input logic d_we,
                             input logic [DBG_ADDR_W-1:0] d_addr,
                             input logic [DATA_W-1:0] d_wdata,
                             input logic s_req, input logic s_we,
                             input logic [SYS_ADDR_W-1:0] s_addr,
                             input logic [LANES-1:0] s_be, input logic [DATA_W-1:0] s_wdata);
    @(posedge clk_i);
    debug_req_i   <= d_req;
    debug_we_i    <= d_we;
    debug_addr_i  <= d_addr;
    debug_wdata_i <= d_wdata;
    sys_req_i     <= s_req;
    sys_we_i      <= s_we;
    sys_addr_i    <= s_addr;
    sys_be_i      <= s_be;
    sys_wdata_i   <= s_wdata;
    flush_req_i   <= 1'b0;
    flush_ack_i   <= 1'b0;
  endtask

  task automatic debug_write(input logic [DBG_ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    drive_cycle(1'b1, 1'b1, a, d, 1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic debug_read(input logic [DBG_ADDR_W-1:0] a);
    drive_cycle(1'b1, 1'b0, a, '0, 1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic flush_cycle(input logic req, input logic ack);
    @(posedge clk_i);
    debug_req_i <= 1'b0;
    sys_req_i   <= 1'b0;
    flush_req_i <= req;
    flush_ack_i <= ack;
  endtask

  // reference model, same edge as the DUT so reads see the old word
  always @(posedge clk_i) begin
    if (debug_req_i && !debug_we_i) begin
      case (region_of(debug_addr_i))
        RG_MEM:  exp_dbg_q <= ref_mem[debug_addr_i[ADDR_LSB +: WORD_ADDR_W]];
        RG_CTRL: exp_dbg_q <= {{(DATA_W-2){1'b0}}, model_fetch_dis, model_halt};
        default: exp_dbg_q <= FILLER_WORD;
      endcase
    end
    if (sys_req_i && !sys_we_i) exp_sys_q <= ref_mem[sys_addr_i[ADDR_LSB +: WORD_ADDR_W]];
    if (debug_req_i && debug_we_i && region_of(debug_addr_i) == RG_MEM) begin
      ref_mem[debug_addr_i[ADDR_LSB +: WORD_ADDR_W]] <= debug_wdata_i;  // whole word
    end
    if (sys_req_i && sys_we_i) begin
      ref_mem[sys_addr_i[ADDR_LSB +: WORD_ADDR_W]] <=
        merge_bytes(ref_mem[sys_addr_i[ADDR_LSB +: WORD_ADDR_W]], sys_wdata_i, sys_be_i);
    end
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      model_halt      <= 1'b0;
      model_fetch_dis <= 1'b0;
      model_flush     <= 1'b0;
      sys_seen_q      <= 1'b0;
    end else begin
      if (debug_req_i && debug_we_i && region_of(debug_addr_i) == RG_CTRL) begin
        model_halt      <= debug_wdata_i[CTRL_HALT_BIT];
        model_fetch_dis <= debug_wdata_i[CTRL_FETCH_DIS_BIT];
      end
      if (flush_req_i) model_flush <= 1'b1;         // request beats acknowledge
      else if (flush_ack_i) model_flush <= 1'b0;
      if (sys_req_i && !sys_we_i) sys_seen_q <= 1'b1;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles without finishing the tests", TIMEOUT_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  a_reset_values : assert property (@(posedge clk_i)
    (!rst_ni && cycle_cnt > 1) |->
      (!debug_rvalid_o && !debug_halt_req_o && !flushing_o && fetch_enable_o))
    else begin
      err_ctrl++;
      $display("error at %0t: outputs not at their reset values", $time);
    end

  a_rvalid_timing : assert property (@(posedge clk_i) disable iff (!rst_ni)
    debug_rvalid_o == $past(debug_req_i && !debug_we_i))
    else begin
      err_timing++;
      $display("error at %0t: debug read valid not one cycle after a read strobe", $time);
    end

  a_debug_rdata : assert property (@(posedge clk_i) disable iff (!rst_ni)
    debug_rvalid_o |-> debug_rdata_o == exp_dbg_q)
    else begin
      err_data++;
      $display("error at %0t: debug read %h, expected %h", $time,
               $sampled(debug_rdata_o), $sampled(exp_dbg_q));
    end

  a_sys_rdata : assert property (@(posedge clk_i) disable iff (!rst_ni)
    sys_seen_q |-> sys_rdata_o == exp_sys_q)      // also covers holding between reads
    else begin
      err_data++;
      $display("error at %0t: system read %h, expected %h", $time,
               $sampled(sys_rdata_o), $sampled(exp_sys_q));
    end

  a_ctrl_outputs : assert property (@(posedge clk_i) disable iff (!rst_ni)
    debug_halt_req_o == model_halt && fetch_enable_o == !model_fetch_dis)
    else begin
      err_ctrl++;
      $display("error at %0t: halt %b fetch enable %b, expected %b %b", $time,
               $sampled(debug_halt_req_o), $sampled(fetch_enable_o),
               $sampled(model_halt), !$sampled(model_fetch_dis));
    end

  a_flush_level : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flushing_o == model_flush)
    else begin
      err_ctrl++;
      $display("error at %0t: flushing %b, expected %b", $time,
               $sampled(flushing_o), $sampled(model_flush));
    end

  a_flush_set : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_req_i |=> flushing_o)
    else begin
      err_ctrl++;
      $display("error at %0t: flushing not set after a request", $time);
    end

  initial begin
    logic [31:0]            r;
    logic [DATA_W-1:0]      d;
    logic [DATA_W-1:0]      s;
    logic [DBG_ADDR_W-1:0]  a;
    logic [WORD_ADDR_W-1:0] dw;
    logic [WORD_ADDR_W-1:0] sw;
    logic                   dq;
    logic                   dwe;
    logic                   sq;
    logic                   swe;
    rst_ni        <= 1'b0;
    debug_req_i   <= 1'b0;
    debug_we_i    <= 1'b0;
    debug_addr_i  <= '0;
    debug_wdata_i <= '0;
    sys_req_i     <= 1'b0;
    sys_we_i      <= 1'b0;
    sys_addr_i    <= '0;
    sys_be_i      <= '0;
    sys_wdata_i   <= '0;
    flush_req_i   <= 1'b0;
    flush_ack_i   <= 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int i = 0; i < POOL; i++) begin          // pick words, fill them from debug
      next_random(r);
      pool[i] = r[WORD_ADDR_W-1:0];
    end
    for (int i = 0; i < POOL; i++) begin
      random_word(d);
      next_random(r);
      debug_write(region_addr(pool[i], MEM_REGION, r[31:24]), d);
    end
    for (int i = 0; i < POOL; i++) debug_read(region_addr(pool[i], MEM_REGION, 8'h00));

    repeat (64) begin                              // byte-masked system writes
      next_random(r);
      random_word(d);
      drive_cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b1, {pool[r[3:0]], r[6:4]}, r[15:8], d);
    end
    for (int i = 0; i < POOL; i++) debug_read(region_addr(pool[i], MEM_REGION, 8'h00));

    for (int i = 0; i < POOL; i++) begin           // debug write then system read
      random_word(d);
      debug_write(region_addr(pool[i], MEM_REGION, 8'h00), d);
      drive_cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b0, {pool[i], 3'd0}, '0, '0);
    end
    for (int i = 0; i < POOL; i++) begin           // same word, same cycle on both ports
      random_word(d);
      random_word(s);
      next_random(r);
      a = region_addr(pool[i], MEM_REGION, 8'h00);
      drive_cycle(1'b1, 1'b0, a, '0, 1'b1, 1'b1, {pool[i], 3'd0}, r[7:0], s);
      drive_cycle(1'b1, 1'b1, a, d, 1'b1, 1'b0, {pool[i], 3'd0}, '0, '0);
      drive_cycle(1'b1, 1'b0, a, '0, 1'b1, 1'b0, {pool[i], 3'd0}, '0, '0);
    end

    for (int i = 0; i < MIXED_CYCLES; i++) begin   // random traffic on both ports
      next_random(r);
      random_word(d);
      random_word(s);
      dw  = pool[r[7:4]];
      sw  = pool[r[11:8]];
      dq  = r[1:0] != 2'd0;
      dwe = r[1:0] == 2'd3;
      sq  = r[3:2] != 2'd0;
      swe = r[3:2] == 2'd3;
      if (dq && dwe && sq && swe && dw == sw) swe = 1'b0;  // no same-word double write
      drive_cycle(dq, dwe, region_addr(dw, MEM_REGION, r[31:24]), d,
                  sq, swe, {sw, r[14:12]}, r[23:16], s);
    end

    for (int i = 0; i < 20; i++) begin             // unmapped and wrong-tag accesses
      next_random(r);
      random_word(d);
      if (i % 2 == 0) a = region_addr(pool[r[3:0]], {1'b0, r[6:4]}, r[31:24]);
      else a = region_addr(pool[r[3:0]], CTRL_REGION, r[31:24] & 8'hFE);
      debug_write(a, d);
      debug_read(a);
    end
    for (int i = 0; i < POOL; i++) debug_read(region_addr(pool[i], MEM_REGION, 8'h00));

    for (int i = 0; i < 4; i++) begin              // all four control patterns
      random_word(d);
      next_random(r);
      d[CTRL_HALT_BIT]      = ~i[0];
      d[CTRL_FETCH_DIS_BIT] = i[1];
      a = region_addr(r[WORD_ADDR_W-1:0], CTRL_REGION, CTRL_TAG);
      debug_write(a, d);
      debug_read(a);
    end

    flush_cycle(1'b1, 1'b0);
    repeat (3) flush_cycle(1'b0, 1'b0);            // level holds without ack
    flush_cycle(1'b0, 1'b1);
    flush_cycle(1'b0, 1'b0);
    flush_cycle(1'b0, 1'b1);                       // ack while idle
    flush_cycle(1'b1, 1'b0);
    flush_cycle(1'b1, 1'b1);                       // tie keeps it set
    flush_cycle(1'b0, 1'b0);
    flush_cycle(1'b0, 1'b1);
    repeat (4) flush_cycle(1'b0, 1'b0);

    $display("checks failed: %0d data, %0d timing, %0d control", err_data, err_timing, err_ctrl);
    if (err_data + err_timing + err_ctrl == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
source/shared_mem_pkg.sv
source/debug_decode.sv
source/byte_lane_ram.sv
source/readback_mux.sv
source/core_ctrl.sv
source/shared_mem_top.sv
testbench/tb_shared_mem.sv

// File: run.sh
#!/usr/bin/env bash
# Build the scratchpad testbench with Verilator, run it and check the log for the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_shared_mem --Mdir "$OBJ" -o tb_shared_mem -f list.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/tb_shared_mem" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
  exit 0
else
  echo "pass line not found in $LOG"
  exit 1
fi
